/* design/csi2_macros.svh */
// Widths fixed by the CSI-2 control register map
// The AXI address is a byte address; registers are 32-bit words
`ifndef CSI2_MACROS_SVH
`define CSI2_MACROS_SVH

// Register and AXI data word
`define CSI2_DATA_W 32

// AXI byte address
`define CSI2_ADDR_W 8

// IDELAY tap value
`define CSI2_DELAY_W 5

// SCCB 7-bit slave address
`define CSI2_SCCB_W 7

// Control plus status registers
`define CSI2_REG_CNT 13

`endif

/* design/csi2_pkg.sv */
// Register indices, packet data types and the 32-bit packet header layout
// Header byte order follows CSI-2, with the data identifier in the low byte
`default_nettype none

`include "csi2_macros.svh"

package csi2_pkg;

  // Word index of each CSR, control registers come first
  typedef enum logic [3:0] {
    CLEAR_STAT          = 4'd0,
    PHY_ENABLE          = 4'd1,
    SCCB_SLAVE_ADDR     = 4'd2,
    LANE_0_DELAY        = 4'd3,
    LANE_1_DELAY        = 4'd4,
    DELAY_ACT           = 4'd5,
    HEADER_ERR_CNT      = 4'd6,
    CORR_HEADER_ERR_CNT = 4'd7,
    CRC_ERR_CNT         = 4'd8,
    MAX_LN_PER_FRAME    = 4'd9,
    MIN_LN_PER_FRAME    = 4'd10,
    MAX_PX_PER_LN       = 4'd11,
    MIN_PX_PER_LN       = 4'd12
  } csr_reg_e;

  // Synchronization short packet codes
  typedef enum logic [5:0] {
    FRAME_START = 6'h00,
    FRAME_END   = 6'h01,
    LINE_START  = 6'h02,
    LINE_END    = 6'h03
  } csi2_dt_e;

  // Lowest data type of a long packet
  localparam logic [5:0] LONG_DT_MIN = 6'h10;

  typedef struct packed {
    logic [7:0]  ecc;
    logic [15:0] frame_number;
    logic [1:0]  vc;
    logic [5:0]  dt;
  } short_hdr_t;

  typedef struct packed {
    logic [7:0]  ecc;
    logic [15:0] word_count;
    logic [1:0]  vc;
    logic [5:0]  dt;
  } long_hdr_t;

  typedef union packed {
    short_hdr_t short_hdr;
    long_hdr_t  long_hdr;
  } pkt_hdr_u;

  typedef enum logic [1:0] {
    IDLE,
    IN_FRAME,
    IN_LINE
  } frame_state_e;

  // Increment that holds at all ones
  function automatic logic [`CSI2_DATA_W-1:0] sat_inc(logic [`CSI2_DATA_W-1:0] value);
    return (&value) ? value : value + 1'b1;
  endfunction

endpackage

`default_nettype wire

/* design/csi2_csr.sv */
// AXI4-Lite CSR block, always ready, responses exactly one cycle after the request
// awvalid_i and wvalid_i must arrive together; bready_i and rready_i are not observed
`default_nettype none

`include "csi2_macros.svh"

module csi2_csr (
  input  wire logic                        clk_i,
  input  wire logic                        rst_i,
  input  wire logic                        awvalid_i,
  output logic                             awready_o,
  input  wire logic [`CSI2_ADDR_W-1:0]     awaddr_i,
  input  wire logic                        wvalid_i,
  output logic                             wready_o,
  input  wire logic [`CSI2_DATA_W-1:0]     wdata_i,
  input  wire logic [`CSI2_DATA_W/8-1:0]   wstrb_i,
  output logic                             bvalid_o,
  input  wire logic                        bready_i,
  output logic [1:0]                       bresp_o,
  input  wire logic                        arvalid_i,
  output logic                             arready_o,
  input  wire logic [`CSI2_ADDR_W-1:0]     araddr_i,
  output logic                             rvalid_o,
  input  wire logic                        rready_i,
  output logic [`CSI2_DATA_W-1:0]          rdata_o,
  output logic [1:0]                       rresp_o,
  output logic                             clear_stat_o,
  output logic                             phy_en_o,
  output logic [`CSI2_SCCB_W-1:0]          sccb_slave_addr_o,
  output logic [`CSI2_DELAY_W-1:0]         lane_0_delay_o,
  output logic [`CSI2_DELAY_W-1:0]         lane_1_delay_o,
  output logic                             delay_act_o,
  input  wire logic [`CSI2_DATA_W-1:0]     header_err_cnt_i,
  input  wire logic [`CSI2_DATA_W-1:0]     corr_header_err_cnt_i,
  input  wire logic [`CSI2_DATA_W-1:0]     crc_err_cnt_i,
  input  wire logic [`CSI2_DATA_W-1:0]     max_ln_per_frame_i,
  input  wire logic [`CSI2_DATA_W-1:0]     min_ln_per_frame_i,
  input  wire logic [`CSI2_DATA_W-1:0]     max_px_per_ln_i,
  input  wire logic [`CSI2_DATA_W-1:0]     min_px_per_ln_i
);

  localparam int BYTE_CNT = `CSI2_DATA_W / 8;
  localparam int WORD_LSB = $clog2(BYTE_CNT);
  localparam int IDX_W    = `CSI2_ADDR_W - WORD_LSB;
  localparam int CTRL_CNT = int'(csi2_pkg::HEADER_ERR_CNT);
  localparam int STAT_CNT = `CSI2_REG_CNT - CTRL_CNT;

  logic [CTRL_CNT-1:0][`CSI2_DATA_W-1:0] ctrl_q;
  logic [STAT_CNT-1:0][`CSI2_DATA_W-1:0] stat_w;
  logic [IDX_W-1:0]                      wr_idx;
  logic [IDX_W-1:0]                      rd_idx;
  logic [`CSI2_DATA_W-1:0]               rd_word;
  logic                                  wr_en;
  logic                                  clear_stat_q;
  logic                                  delay_act_q;

  assign awready_o = 1'b1;
  assign wready_o  = 1'b1;
  assign arready_o = 1'b1;
  assign bresp_o   = 2'b00;
  assign rresp_o   = 2'b00;

  assign wr_idx = awaddr_i[`CSI2_ADDR_W-1:WORD_LSB];
  assign rd_idx = araddr_i[`CSI2_ADDR_W-1:WORD_LSB];
  assign wr_en  = awvalid_i && wvalid_i;

  // Responses trail the request by one cycle, no wait states
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      bvalid_o <= 1'b0;
      rvalid_o <= 1'b0;
    end
    else
    begin
      bvalid_o <= wr_en;
      rvalid_o <= arvalid_i;
    end
  end

  // Status indices are read only, writes to them are dropped
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      ctrl_q <= '0;
    else if (wr_en && (wr_idx < CTRL_CNT))
    begin
      for (int b = 0; b < BYTE_CNT; b++)
      begin
        if (wstrb_i[b])
          ctrl_q[wr_idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
      end
    end
  end

  assign stat_w[csi2_pkg::HEADER_ERR_CNT - CTRL_CNT]      = header_err_cnt_i;
  assign stat_w[csi2_pkg::CORR_HEADER_ERR_CNT - CTRL_CNT] = corr_header_err_cnt_i;
  assign stat_w[csi2_pkg::CRC_ERR_CNT - CTRL_CNT]         = crc_err_cnt_i;
  assign stat_w[csi2_pkg::MAX_LN_PER_FRAME - CTRL_CNT]    = max_ln_per_frame_i;
  assign stat_w[csi2_pkg::MIN_LN_PER_FRAME - CTRL_CNT]    = min_ln_per_frame_i;
  assign stat_w[csi2_pkg::MAX_PX_PER_LN - CTRL_CNT]       = max_px_per_ln_i;
  assign stat_w[csi2_pkg::MIN_PX_PER_LN - CTRL_CNT]       = min_px_per_ln_i;

  // Unmapped word indices read as zero
  always_comb
  begin
    if (rd_idx < CTRL_CNT)
      rd_word = ctrl_q[rd_idx];
    else if (rd_idx < `CSI2_REG_CNT)
      rd_word = stat_w[rd_idx - CTRL_CNT];
    else
      rd_word = '0;
  end

  always_ff @(posedge clk_i)
  begin
    if (arvalid_i)
      rdata_o <= rd_word;
  end

  // Previous value of the strobe bits for rising edge detection
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      clear_stat_q <= 1'b0;
      delay_act_q  <= 1'b0;
    end
    else
    begin
      clear_stat_q <= ctrl_q[csi2_pkg::CLEAR_STAT][0];
      delay_act_q  <= ctrl_q[csi2_pkg::DELAY_ACT][0];
    end
  end

  assign clear_stat_o      = ctrl_q[csi2_pkg::CLEAR_STAT][0] && !clear_stat_q;
  assign delay_act_o       = ctrl_q[csi2_pkg::DELAY_ACT][0] && !delay_act_q;
  assign phy_en_o          = ctrl_q[csi2_pkg::PHY_ENABLE][0];
  assign sccb_slave_addr_o = ctrl_q[csi2_pkg::SCCB_SLAVE_ADDR][`CSI2_SCCB_W-1:0];
  assign lane_0_delay_o    = ctrl_q[csi2_pkg::LANE_0_DELAY][`CSI2_DELAY_W-1:0];
  assign lane_1_delay_o    = ctrl_q[csi2_pkg::LANE_1_DELAY][`CSI2_DELAY_W-1:0];

endmodule

`default_nettype wire

/* design/csi2_frame_fsm.sv */
// Frame and line tracking from decoded packet headers
// Headers out of sequence are dropped; all pulses come one cycle after their cause
`default_nettype none

module csi2_frame_fsm (
  input  wire logic               clk_i,
  input  wire logic               rst_i,
  input  wire logic               hdr_valid_i,
  input  wire csi2_pkg::pkt_hdr_u hdr_i,
  input  wire logic               pkt_end_i,
  output logic                    line_start_o,
  output logic                    line_done_o,
  output logic                    frame_done_o,
  output logic                    px_count_en_o
);

  csi2_pkg::frame_state_e state_q;
  csi2_pkg::frame_state_e state_d;
  logic                   is_fs;
  logic                   is_fe;
  logic                   is_long;

  // Frame packets use the short view, line packets the long view
  assign is_fs   = hdr_valid_i && (hdr_i.short_hdr.dt == csi2_pkg::FRAME_START);
  assign is_fe   = hdr_valid_i && (hdr_i.short_hdr.dt == csi2_pkg::FRAME_END);
  assign is_long = hdr_valid_i && (hdr_i.long_hdr.dt >= csi2_pkg::LONG_DT_MIN);

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      csi2_pkg::IDLE:
        if (is_fs)
          state_d = csi2_pkg::IN_FRAME;
      csi2_pkg::IN_FRAME:
        if (is_fe)
          state_d = csi2_pkg::IDLE;
        else if (is_long)
          state_d = csi2_pkg::IN_LINE;
      csi2_pkg::IN_LINE:
        if (pkt_end_i)
          state_d = csi2_pkg::IN_FRAME;
      default:
        state_d = csi2_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state_q      <= csi2_pkg::IDLE;
      line_start_o <= 1'b0;
      line_done_o  <= 1'b0;
      frame_done_o <= 1'b0;
    end
    else
    begin
      state_q      <= state_d;
      line_start_o <= (state_q == csi2_pkg::IN_FRAME) && is_long;
      line_done_o  <= (state_q == csi2_pkg::IN_LINE) && pkt_end_i;
      frame_done_o <= (state_q == csi2_pkg::IN_FRAME) && is_fe;
    end
  end

  // High for the payload of a long packet, starting with line_start_o
  assign px_count_en_o = (state_q == csi2_pkg::IN_LINE);

endmodule

`default_nettype wire

/* design/csi2_len_counter.sv */
// Pixels per line and lines per frame, both saturating at all ones
// A pixel in the line_start_i cycle already counts toward the new line
`default_nettype none

`include "csi2_macros.svh"

module csi2_len_counter (
  input  wire logic                    clk_i,
  input  wire logic                    rst_i,
  input  wire logic                    line_start_i,
  input  wire logic                    px_count_en_i,
  input  wire logic                    px_valid_i,
  input  wire logic                    frame_done_i,
  output logic [`CSI2_DATA_W-1:0]      px_cnt_o,
  output logic [`CSI2_DATA_W-1:0]      ln_cnt_o
);

  logic px_hit;

  assign px_hit = px_count_en_i && px_valid_i;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      px_cnt_o <= '0;
    else if (line_start_i)
      px_cnt_o <= `CSI2_DATA_W'(px_hit);
    else if (px_hit)
      px_cnt_o <= csi2_pkg::sat_inc(px_cnt_o);
  end

  // Count stays valid through the frame_done_i cycle for the accumulator
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      ln_cnt_o <= '0;
    else if (frame_done_i)
      ln_cnt_o <= '0;
    else if (line_start_i)
      ln_cnt_o <= csi2_pkg::sat_inc(ln_cnt_o);
  end

endmodule

`default_nettype wire

/* design/csi2_stat_acc.sv */
// Error counters and min/max line statistics, cleared by reset or clear_stat_i
// Min values start at all ones so the first sample always replaces them
`default_nettype none

`include "csi2_macros.svh"

module csi2_stat_acc (
  input  wire logic                    clk_i,
  input  wire logic                    rst_i,
  input  wire logic                    clear_stat_i,
  input  wire logic                    hdr_valid_i,
  input  wire logic                    hdr_err_i,
  input  wire logic                    hdr_corr_i,
  input  wire logic                    pkt_end_i,
  input  wire logic                    crc_err_i,
  input  wire logic                    line_done_i,
  input  wire logic                    frame_done_i,
  input  wire logic [`CSI2_DATA_W-1:0] px_cnt_i,
  input  wire logic [`CSI2_DATA_W-1:0] ln_cnt_i,
  output logic [`CSI2_DATA_W-1:0]      header_err_cnt_o,
  output logic [`CSI2_DATA_W-1:0]      corr_header_err_cnt_o,
  output logic [`CSI2_DATA_W-1:0]      crc_err_cnt_o,
  output logic [`CSI2_DATA_W-1:0]      max_ln_per_frame_o,
  output logic [`CSI2_DATA_W-1:0]      min_ln_per_frame_o,
  output logic [`CSI2_DATA_W-1:0]      max_px_per_ln_o,
  output logic [`CSI2_DATA_W-1:0]      min_px_per_ln_o
);

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      header_err_cnt_o      <= '0;
      corr_header_err_cnt_o <= '0;
      crc_err_cnt_o         <= '0;
    end
    else if (clear_stat_i)
    begin
      header_err_cnt_o      <= '0;
      corr_header_err_cnt_o <= '0;
      crc_err_cnt_o         <= '0;
    end
    else
    begin
      if (hdr_valid_i && hdr_err_i)
        header_err_cnt_o <= csi2_pkg::sat_inc(header_err_cnt_o);
      if (hdr_valid_i && hdr_corr_i)
        corr_header_err_cnt_o <= csi2_pkg::sat_inc(corr_header_err_cnt_o);
      // CRC result rides on the end strobe
      if (pkt_end_i && crc_err_i)
        crc_err_cnt_o <= csi2_pkg::sat_inc(crc_err_cnt_o);
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      max_px_per_ln_o    <= '0;
      min_px_per_ln_o    <= '1;
      max_ln_per_frame_o <= '0;
      min_ln_per_frame_o <= '1;
    end
    else if (clear_stat_i)
    begin
      max_px_per_ln_o    <= '0;
      min_px_per_ln_o    <= '1;
      max_ln_per_frame_o <= '0;
      min_ln_per_frame_o <= '1;
    end
    else
    begin
      if (line_done_i && (px_cnt_i > max_px_per_ln_o))
        max_px_per_ln_o <= px_cnt_i;
      if (line_done_i && (px_cnt_i < min_px_per_ln_o))
        min_px_per_ln_o <= px_cnt_i;
      if (frame_done_i && (ln_cnt_i > max_ln_per_frame_o))
        max_ln_per_frame_o <= ln_cnt_i;
      if (frame_done_i && (ln_cnt_i < min_ln_per_frame_o))
        min_ln_per_frame_o <= ln_cnt_i;
    end
  end

endmodule

`default_nettype wire

/* design/csi2_ctrl_top.sv */
// CSI-2 receiver control and statistics, fed by an external header decoder
// Packet stream has no back-pressure and is taken every cycle
`default_nettype none

`include "csi2_macros.svh"

module csi2_ctrl_top (
  input  wire logic                        clk_i,
  input  wire logic                        rst_i,
  input  wire logic                        awvalid_i,
  output logic                             awready_o,
  input  wire logic [`CSI2_ADDR_W-1:0]     awaddr_i,
  input  wire logic                        wvalid_i,
  output logic                             wready_o,
  input  wire logic [`CSI2_DATA_W-1:0]     wdata_i,
  input  wire logic [`CSI2_DATA_W/8-1:0]   wstrb_i,
  output logic                             bvalid_o,
  input  wire logic                        bready_i,
  output logic [1:0]                       bresp_o,
  input  wire logic                        arvalid_i,
  output logic                             arready_o,
  input  wire logic [`CSI2_ADDR_W-1:0]     araddr_i,
  output logic                             rvalid_o,
  input  wire logic                        rready_i,
  output logic [`CSI2_DATA_W-1:0]          rdata_o,
  output logic [1:0]                       rresp_o,
  input  wire logic                        hdr_valid_i,
  input  wire csi2_pkg::pkt_hdr_u          hdr_i,
  input  wire logic                        hdr_err_i,
  input  wire logic                        hdr_corr_i,
  input  wire logic                        px_valid_i,
  input  wire logic                        pkt_end_i,
  input  wire logic                        crc_err_i,
  output logic                             phy_en_o,
  output logic [`CSI2_SCCB_W-1:0]          sccb_slave_addr_o,
  output logic [`CSI2_DELAY_W-1:0]         lane_0_delay_o,
  output logic [`CSI2_DELAY_W-1:0]         lane_1_delay_o,
  output logic                             delay_act_o
);

  logic                    clear_stat;
  logic                    line_start;
  logic                    line_done;
  logic                    frame_done;
  logic                    px_count_en;
  logic [`CSI2_DATA_W-1:0] px_cnt;
  logic [`CSI2_DATA_W-1:0] ln_cnt;
  logic [`CSI2_DATA_W-1:0] header_err_cnt;
  logic [`CSI2_DATA_W-1:0] corr_header_err_cnt;
  logic [`CSI2_DATA_W-1:0] crc_err_cnt;
  logic [`CSI2_DATA_W-1:0] max_ln_per_frame;
  logic [`CSI2_DATA_W-1:0] min_ln_per_frame;
  logic [`CSI2_DATA_W-1:0] max_px_per_ln;
  logic [`CSI2_DATA_W-1:0] min_px_per_ln;

  csi2_csr u_csr (
    .clk_i                 (clk_i),
    .rst_i                 (rst_i),
    .awvalid_i             (awvalid_i),
    .awready_o             (awready_o),
    .awaddr_i              (awaddr_i),
    .wvalid_i              (wvalid_i),
    .wready_o              (wready_o),
    .wdata_i               (wdata_i),
    .wstrb_i               (wstrb_i),
    .bvalid_o              (bvalid_o),
    .bready_i              (bready_i),
    .bresp_o               (bresp_o),
    .arvalid_i             (arvalid_i),
    .arready_o             (arready_o),
    .araddr_i              (araddr_i),
    .rvalid_o              (rvalid_o),
    .rready_i              (rready_i),
    .rdata_o               (rdata_o),
    .rresp_o               (rresp_o),
    .clear_stat_o          (clear_stat),
    .phy_en_o              (phy_en_o),
    .sccb_slave_addr_o     (sccb_slave_addr_o),
    .lane_0_delay_o        (lane_0_delay_o),
    .lane_1_delay_o        (lane_1_delay_o),
    .delay_act_o           (delay_act_o),
    .header_err_cnt_i      (header_err_cnt),
    .corr_header_err_cnt_i (corr_header_err_cnt),
    .crc_err_cnt_i         (crc_err_cnt),
    .max_ln_per_frame_i    (max_ln_per_frame),
    .min_ln_per_frame_i    (min_ln_per_frame),
    .max_px_per_ln_i       (max_px_per_ln),
    .min_px_per_ln_i       (min_px_per_ln)
  );

  csi2_frame_fsm u_frame_fsm (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .hdr_valid_i   (hdr_valid_i),
    .hdr_i         (hdr_i),
    .pkt_end_i     (pkt_end_i),
    .line_start_o  (line_start),
    .line_done_o   (line_done),
    .frame_done_o  (frame_done),
    .px_count_en_o (px_count_en)
  );

  csi2_len_counter u_len_counter (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .line_start_i  (line_start),
    .px_count_en_i (px_count_en),
    .px_valid_i    (px_valid_i),
    .frame_done_i  (frame_done),
    .px_cnt_o      (px_cnt),
    .ln_cnt_o      (ln_cnt)
  );

  csi2_stat_acc u_stat_acc (
    .clk_i                 (clk_i),
    .rst_i                 (rst_i),
    .clear_stat_i          (clear_stat),
    .hdr_valid_i           (hdr_valid_i),
    .hdr_err_i             (hdr_err_i),
    .hdr_corr_i            (hdr_corr_i),
    .pkt_end_i             (pkt_end_i),
    .crc_err_i             (crc_err_i),
    .line_done_i           (line_done),
    .frame_done_i          (frame_done),
    .px_cnt_i              (px_cnt),
    .ln_cnt_i              (ln_cnt),
    .header_err_cnt_o      (header_err_cnt),
    .corr_header_err_cnt_o (corr_header_err_cnt),
    .crc_err_cnt_o         (crc_err_cnt),
    .max_ln_per_frame_o    (max_ln_per_frame),
    .min_ln_per_frame_o    (min_ln_per_frame),
    .max_px_per_ln_o       (max_px_per_ln),
    .min_px_per_ln_o       (min_px_per_ln)
  );

endmodule

`default_nettype wire

/* verif/csi2_asserts.sv */
// Protocol checks bound into the CSR block
// Responses must trail their request by exactly one cycle
`default_nettype none

module csi2_asserts (
  input wire logic clk_i,
  input wire logic rst_i,
  input wire logic awvalid_i,
  input wire logic wvalid_i,
  input wire logic arvalid_i,
  input wire logic bvalid_o,
  input wire logic rvalid_o,
  input wire logic delay_act_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // Write response one cycle after address and data meet
  write_resp_timing: assert property (@(posedge clk_i) disable iff (rst_i)
    (awvalid_i && wvalid_i) |=> bvalid_o)
    else $error("bvalid did not follow a write by one cycle");

  no_spurious_bvalid: assert property (@(posedge clk_i) disable iff (rst_i)
    !(awvalid_i && wvalid_i) |=> !bvalid_o)
    else $error("bvalid without a write");

  read_resp_timing: assert property (@(posedge clk_i) disable iff (rst_i)
    arvalid_i |=> rvalid_o)
    else $error("rvalid did not follow arvalid by one cycle");

  // Actualize strobe is a single cycle wide
  delay_act_width: assert property (@(posedge clk_i) disable iff (rst_i)
    delay_act_o |=> !delay_act_o)
    else $error("delay_act high for two cycles");

endmodule

bind csi2_csr csi2_asserts asserts_i (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .awvalid_i   (awvalid_i),
  .wvalid_i    (wvalid_i),
  .arvalid_i   (arvalid_i),
  .bvalid_o    (bvalid_o),
  .rvalid_o    (rvalid_o),
  .delay_act_o (delay_act_o)
);

`default_nettype wire

/* verif/csi2_tb.sv */
// Testbench for the CSI-2 control top with random line and pixel counts from a fixed seed
// AXI master presents address and data together and takes every response at once
`default_nettype none

`include "csi2_macros.svh"

module csi2_tb;

  timeunit 1ns;
  timeprecision 1ps;

  // Worst case frames of 4 lines of 8 pixels, plus bus transfers of about 6 cycles
  localparam int PKT_CYCLES = 8 * (4 * (2 * 8 + 8) + 8) + 40;
  localparam int BUS_CYCLES = 120 * 6;
  localparam int LIMIT      = 2 * (PKT_CYCLES + BUS_CYCLES) + 16;

  logic                        clk_i;
  logic                        rst_i;
  logic                        awvalid_i;
  logic                        awready_o;
  logic [`CSI2_ADDR_W-1:0]     awaddr_i;
  logic                        wvalid_i;
  logic                        wready_o;
  logic [`CSI2_DATA_W-1:0]     wdata_i;
  logic [`CSI2_DATA_W/8-1:0]   wstrb_i;
  logic                        bvalid_o;
  logic                        bready_i;
  logic [1:0]                  bresp_o;
  logic                        arvalid_i;
  logic                        arready_o;
  logic [`CSI2_ADDR_W-1:0]     araddr_i;
  logic                        rvalid_o;
  logic                        rready_i;
  logic [`CSI2_DATA_W-1:0]     rdata_o;
  logic [1:0]                  rresp_o;
  logic                        hdr_valid_i;
  csi2_pkg::pkt_hdr_u          hdr_i;
  logic                        hdr_err_i;
  logic                        hdr_corr_i;
  logic                        px_valid_i;
  logic                        pkt_end_i;
  logic                        crc_err_i;
  logic                        phy_en_o;
  logic [`CSI2_SCCB_W-1:0]     sccb_slave_addr_o;
  logic [`CSI2_DELAY_W-1:0]    lane_0_delay_o;
  logic [`CSI2_DELAY_W-1:0]    lane_1_delay_o;
  logic                        delay_act_o;

  integer                      seed = 13467;
  int                          err_cnt;
  int                          check_cnt;
  int                          test_cnt;
  int                          test_err_base;
  int                          cycle_cnt;
  int                          pulse_cnt;
  int                          exp_hdr_err;
  int                          exp_corr_err;
  int                          exp_crc_err;
  int unsigned                 px_log[$];
  int unsigned                 ln_log[$];
  logic [`CSI2_DATA_W-1:0]     ctrl_exp [6];

  csi2_ctrl_top dut_i (.*);

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i)
  begin
    cycle_cnt++;
    if (cycle_cnt > LIMIT)
    begin
      $display("timeout: run exceeded %0d cycles without finishing", LIMIT);
      $display("TEST FAILED");
      $finish;
    end
  end

  always @(negedge clk_i)
  begin
    if (!rst_i && delay_act_o)
      pulse_cnt++;
  end

  // Expected statistic from the logged stimulus
  function automatic logic [31:0] ref_stats(csi2_pkg::csr_reg_e idx);
    logic [31:0] v;
    case (idx)
      csi2_pkg::HEADER_ERR_CNT:      v = exp_hdr_err;
      csi2_pkg::CORR_HEADER_ERR_CNT: v = exp_corr_err;
      csi2_pkg::CRC_ERR_CNT:         v = exp_crc_err;
      csi2_pkg::MAX_LN_PER_FRAME:
      begin
        v = '0;
        foreach (ln_log[i])
          if (ln_log[i] > v) v = ln_log[i];
      end
      csi2_pkg::MIN_LN_PER_FRAME:
      begin
        v = '1;
        foreach (ln_log[i])
          if (ln_log[i] < v) v = ln_log[i];
      end
      csi2_pkg::MAX_PX_PER_LN:
      begin
        v = '0;
        foreach (px_log[i])
          if (px_log[i] > v) v = px_log[i];
      end
      csi2_pkg::MIN_PX_PER_LN:
      begin
        v = '1;
        foreach (px_log[i])
          if (px_log[i] < v) v = px_log[i];
      end
      default:                       v = ctrl_exp[idx];
    endcase
    return v;
  endfunction

  function automatic logic [31:0] merge_bytes(logic [31:0] old, logic [31:0] data,
                                              logic [3:0] strb);
    logic [31:0] r;
    r = old;
    for (int b = 0; b < 4; b++)
      if (strb[b]) r[b*8 +: 8] = data[b*8 +: 8];
    return r;
  endfunction

  task automatic compare_word(string what, logic [31:0] got, logic [31:0] exp);
    check_cnt++;
    if (got !== exp)
    begin
      err_cnt++;
      $display("mismatch at %0t: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic axi_write(logic [7:0] addr, logic [31:0] data, logic [3:0] strb);
    int waited;
    @(posedge clk_i);
    awvalid_i <= 1'b1;
    wvalid_i  <= 1'b1;
    awaddr_i  <= addr;
    wdata_i   <= data;
    wstrb_i   <= strb;
    @(posedge clk_i);
    awvalid_i <= 1'b0;
    wvalid_i  <= 1'b0;
    waited = 0;
    @(negedge clk_i);
    while (!bvalid_o && waited < 8)
    begin
      waited++;
      @(negedge clk_i);
    end
    if (!bvalid_o)
    begin
      err_cnt++;
      $display("write to address 0x%02h got no response", addr);
    end
    else
    begin
      if (waited != 0)
      begin
        err_cnt++;
        $display("write to address 0x%02h was answered %0d cycles late", addr, waited);
      end
      compare_word("bresp", bresp_o, 0);
      compare_word("awready_o", awready_o, 1);
      compare_word("wready_o", wready_o, 1);
    end
    if (addr[7:2] < 6)
      ctrl_exp[addr[7:2]] = merge_bytes(ctrl_exp[addr[7:2]], data, strb);
  endtask

  task automatic axi_read(logic [7:0] addr, output logic [31:0] data);
    int waited;
    @(posedge clk_i);
    arvalid_i <= 1'b1;
    araddr_i  <= addr;
    @(posedge clk_i);
    arvalid_i <= 1'b0;
    waited = 0;
    @(negedge clk_i);
    while (!rvalid_o && waited < 8)
    begin
      waited++;
      @(negedge clk_i);
    end
    data = rdata_o;
    if (!rvalid_o)
    begin
      err_cnt++;
      $display("read of address 0x%02h got no response", addr);
    end
    else
    begin
      if (waited != 0)
      begin
        err_cnt++;
        $display("read of address 0x%02h was answered %0d cycles late", addr, waited);
      end
      compare_word("rresp", rresp_o, 0);
      compare_word("arready_o", arready_o, 1);
    end
  endtask

  task automatic check_reg(csi2_pkg::csr_reg_e idx, logic [31:0] exp);
    logic [31:0] got;
    axi_read({2'b00, idx, 2'b00}, got);
    compare_word(idx.name(), got, exp);
  endtask

  task automatic check_ctrl(logic phy, logic [`CSI2_SCCB_W-1:0] sccb,
                            logic [`CSI2_DELAY_W-1:0] l0, logic [`CSI2_DELAY_W-1:0] l1);
    compare_word("phy_en_o", phy_en_o, phy);
    compare_word("sccb_slave_addr_o", sccb_slave_addr_o, sccb);
    compare_word("lane_0_delay_o", lane_0_delay_o, l0);
    compare_word("lane_1_delay_o", lane_1_delay_o, l1);
  endtask

  task automatic check_pulses(int exp);
    compare_word("delay_act pulse count", pulse_cnt, exp);
  endtask

  task automatic check_all_regs();
    for (int i = 0; i < `CSI2_REG_CNT; i++)
      check_reg(csi2_pkg::csr_reg_e'(i), ref_stats(csi2_pkg::csr_reg_e'(i)));
  endtask

  task automatic send_hdr(csi2_pkg::pkt_hdr_u h, logic err, logic corr);
    @(posedge clk_i);
    hdr_valid_i <= 1'b1;
    hdr_i       <= h;
    hdr_err_i   <= err;
    hdr_corr_i  <= corr;
    @(posedge clk_i);
    hdr_valid_i <= 1'b0;
    hdr_err_i   <= 1'b0;
    hdr_corr_i  <= 1'b0;
    exp_hdr_err  += err;
    exp_corr_err += corr;
  endtask

  task automatic send_short(logic [5:0] dt, logic err, logic corr);
    csi2_pkg::pkt_hdr_u h;
    h.short_hdr.ecc          = 8'h00;
    h.short_hdr.frame_number = 16'd1;
    h.short_hdr.vc           = 2'd0;
    h.short_hdr.dt           = dt;
    send_hdr(h, err, corr);
  endtask

  // Long packet with raw RGB888 data type, then pixels and end strobe
  task automatic send_line(int unsigned npx, logic crc);
    csi2_pkg::pkt_hdr_u h;
    h.long_hdr.ecc        = 8'h00;
    h.long_hdr.word_count = 16'(npx);
    h.long_hdr.vc         = 2'd0;
    h.long_hdr.dt         = 6'h24;
    send_hdr(h, 1'b0, 1'b0);
    repeat (npx)
    begin
      @(posedge clk_i);
      px_valid_i <= 1'b1;
    end
    @(posedge clk_i);
    px_valid_i <= 1'b0;
    pkt_end_i  <= 1'b1;
    crc_err_i  <= crc;
    @(posedge clk_i);
    pkt_end_i  <= 1'b0;
    crc_err_i  <= 1'b0;
    exp_crc_err += crc;
  endtask

  task automatic send_frame();
    int unsigned nln;
    int unsigned npx;
    nln = 1 + ($unsigned($random(seed)) % 4);
    send_short(csi2_pkg::FRAME_START, 1'b0, 1'b0);
    for (int l = 0; l < nln; l++)
    begin
      npx = 1 + ($unsigned($random(seed)) % 8);
      send_line(npx, 1'b0);
      px_log.push_back(npx);
    end
    send_short(csi2_pkg::FRAME_END, 1'b0, 1'b0);
    ln_log.push_back(nln);
  endtask

  task automatic end_test(string name);
    test_cnt++;
    $display("test %0d %s: %s", test_cnt, name, (err_cnt == test_err_base) ? "pass" : "fail");
    test_err_base = err_cnt;
  endtask

  initial
  begin
    logic [31:0] data;
    logic [31:0] rd;
    logic [3:0]  strb;
    clk_i       = 1'b0;
    rst_i       = 1'b1;
    awvalid_i   = 1'b0;
    awaddr_i    = '0;
    wvalid_i    = 1'b0;
    wdata_i     = '0;
    wstrb_i     = '0;
    bready_i    = 1'b1;
    arvalid_i   = 1'b0;
    araddr_i    = '0;
    rready_i    = 1'b1;
    hdr_valid_i = 1'b0;
    hdr_i       = '0;
    hdr_err_i   = 1'b0;
    hdr_corr_i  = 1'b0;
    px_valid_i  = 1'b0;
    pkt_end_i   = 1'b0;
    crc_err_i   = 1'b0;
    foreach (ctrl_exp[i])
      ctrl_exp[i] = '0;
    repeat (16) @(posedge clk_i);
    rst_i <= 1'b0;

    check_all_regs();
    check_ctrl(1'b0, '0, '0, '0);
    check_pulses(0);
    end_test("reset values");

    // Full word first, then a random byte mix over it
    for (int i = 1; i < 5; i++)
    begin
      axi_write(8'(i * 4), $random(seed), 4'hf);
      data = $random(seed);
      strb = $random(seed);
      axi_write(8'(i * 4), data, strb);
      check_reg(csi2_pkg::csr_reg_e'(i), ref_stats(csi2_pkg::csr_reg_e'(i)));
    end
    @(negedge clk_i);
    check_ctrl(ctrl_exp[1][0], ctrl_exp[2][`CSI2_SCCB_W-1:0],
               ctrl_exp[3][`CSI2_DELAY_W-1:0], ctrl_exp[4][`CSI2_DELAY_W-1:0]);
    axi_read(8'd52, rd);
    compare_word("unmapped index 13", rd, 0);
    axi_read(8'hfc, rd);
    compare_word("unmapped index 63", rd, 0);
    axi_write(8'd36, 32'h0000_0005, 4'hf);
    axi_write(8'd40, 32'h0000_0000, 4'hf);
    check_reg(csi2_pkg::MAX_LN_PER_FRAME, ref_stats(csi2_pkg::MAX_LN_PER_FRAME));
    check_reg(csi2_pkg::MIN_LN_PER_FRAME, ref_stats(csi2_pkg::MIN_LN_PER_FRAME));
    end_test("control registers");

    axi_write(8'd20, 32'h1, 4'h1);
    repeat (3) @(posedge clk_i);
    check_pulses(1);
    axi_write(8'd20, 32'h1, 4'h1);
    repeat (3) @(posedge clk_i);
    check_pulses(1);
    end_test("delay actualize pulse");

    // Stray long packet before any frame start, longer than any random line
    send_line(12, 1'b0);
    repeat (3)
      send_frame();
    repeat (2) @(posedge clk_i);
    check_all_regs();
    end_test("frame statistics");

    for (int i = 0; i < 5; i++)
      send_short(csi2_pkg::LINE_START, 1'($random(seed)), 1'($random(seed)));
    send_short(csi2_pkg::LINE_END, 1'b1, 1'b1);
    send_line(3, 1'b1);
    send_line(2, 1'b1);
    repeat (2) @(posedge clk_i);
    check_all_regs();
    end_test("error counters");

    axi_write(8'd0, 32'h1, 4'h1);
    exp_hdr_err  = 0;
    exp_corr_err = 0;
    exp_crc_err  = 0;
    px_log.delete();
    ln_log.delete();
    check_all_regs();
    send_frame();
    repeat (2) @(posedge clk_i);
    check_all_regs();
    end_test("clear statistics");

    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+design
design/csi2_pkg.sv
design/csi2_csr.sv
design/csi2_frame_fsm.sv
design/csi2_len_counter.sv
design/csi2_stat_acc.sv
design/csi2_ctrl_top.sv
verif/csi2_asserts.sv
verif/csi2_tb.sv

/* Bender.yml */
package:
  name: csi2_ctrl

sources:
  - include_dirs:
      - design
    files:
      - design/csi2_pkg.sv
      - design/csi2_csr.sv
      - design/csi2_frame_fsm.sv
      - design/csi2_len_counter.sv
      - design/csi2_stat_acc.sv
      - design/csi2_ctrl_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/csi2_asserts.sv
      - verif/csi2_tb.sv
